//--- Bender.yml
package:
  name: dodge_game

sources:
  - files:
      - hdl/dodge_pkg.sv
      - hdl/button_debounce.sv
      - hdl/player_position.sv
      - hdl/obstacle_field.sv
      - hdl/game_control.sv
      - hdl/frame_compose.sv
      - hdl/max7219_driver.sv
      - hdl/dodge_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_checker.sv
      - testbench/tb_dodge.sv

//--- hdl/button_debounce.sv
// Button debouncer with two-flop synchroniser and one-cycle press pulse
module button_debounce (
	input  logic clock_50,
	input  logic rst_n,
	input  logic button_n,
	output logic press
);

	logic [1:0] sync_n;
	logic [dodge_pkg::DEBOUNCE_W-1:0] low_cnt;

	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			sync_n <= 2'b11;
		end else begin
			sync_n <= {sync_n[0], button_n};
		end
	end

	// Count stable low samples, saturate until release
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			low_cnt <= '0;
			press <= 1'b0;
		end else begin
			press <= 1'b0;
			if (sync_n[1]) begin
				low_cnt <= '0;
			end else if (low_cnt != dodge_pkg::DEBOUNCE_W'(dodge_pkg::DEBOUNCE_CYCLES)) begin
				low_cnt <= low_cnt + 1'b1;
				press <= (low_cnt == dodge_pkg::DEBOUNCE_W'(dodge_pkg::DEBOUNCE_CYCLES - 1));
			end
		end
	end

	// A held button never yields a second pulse
	assert property (@(posedge clock_50) disable iff (!rst_n) press |=> !press)
		else $error("press pulse lasted more than one cycle");

endmodule

//--- hdl/dodge_pkg.sv
// Dodge game shared sizes, timing constants, MAX7219 codes and screen patterns
package dodge_pkg;

	// ============================================================
	// Matrix geometry
	// ============================================================
	localparam int MATRIX_SIZE = 8;

	// Bit 7 is the leftmost column
	typedef logic [MATRIX_SIZE-1:0] row_t;
	// Index 0 is the bottom row
	typedef logic [MATRIX_SIZE-1:0][MATRIX_SIZE-1:0] frame_t;
	typedef logic [2:0] digit_t;

	// ============================================================
	// Timing
	// ============================================================
	localparam int DEBOUNCE_CYCLES = 8;
	localparam int DEBOUNCE_W = $clog2(DEBOUNCE_CYCLES + 1);
	localparam int STEP_TICKS = 1200;
	localparam int STEP_W = $clog2(STEP_TICKS);
	// System clocks per half period of the serial clock
	localparam int SPI_DIV = 2;
	localparam int SPI_DIV_W = $clog2(SPI_DIV + 1);

	// Screen select codes, also the game state encoding
	localparam logic [1:0] SCREEN_IDLE = 2'd0;
	localparam logic [1:0] SCREEN_PLAY = 2'd1;
	localparam logic [1:0] SCREEN_OVER = 2'd2;

	// ============================================================
	// MAX7219 registers
	// ============================================================
	localparam logic [7:0] REG_DECODE = 8'h09;
	localparam logic [7:0] REG_INTENSITY = 8'h0A;
	localparam logic [7:0] REG_SCAN_LIMIT = 8'h0B;
	localparam logic [7:0] REG_SHUTDOWN = 8'h0C;
	localparam logic [7:0] REG_DISPLAY_TEST = 8'h0F;
	localparam logic [7:0] INTENSITY = 8'h0A;

	// Player start columns
	localparam row_t PLAYER1_START = 8'b0100_0000;
	localparam row_t PLAYER2_START = 8'b0000_0010;

	localparam logic [7:0] LFSR_SEED = 8'h01;

	// Screens, top row first
	localparam frame_t START_SCREEN = {
		8'b00000000, 8'b01100110, 8'b01000100, 8'b01000100,
		8'b00100010, 8'b00100010, 8'b01100110, 8'b00000000
	};

	// Smiley
	localparam frame_t OVER_SCREEN = {
		8'b00000000, 8'b00100100, 8'b00100100, 8'b00000000,
		8'b01000010, 8'b00100100, 8'b00111100, 8'b00000000
	};

endpackage

//--- hdl/dodge_top.sv
// Two-player dodge game on an 8x8 matrix driven through a MAX7219
module dodge_top (
	input  logic clock_50,
	input  logic rst_n,
	input  logic start_button_n,
	input  logic left_1_n,
	input  logic right_1_n,
	input  logic left_2_n,
	input  logic right_2_n,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);

	logic start_press;
	logic left_1;
	logic right_1;
	logic left_2;
	logic right_2;
	logic play_start;
	logic step;
	logic [1:0] screen;
	dodge_pkg::row_t pos_1;
	dodge_pkg::row_t pos_2;
	dodge_pkg::frame_t frame;
	dodge_pkg::digit_t digit_sel;
	dodge_pkg::row_t digit_data;

	// ============================================================
	// Buttons
	// ============================================================
	button_debounce u_deb_start (.clock_50, .rst_n, .button_n(start_button_n), .press(start_press));
	button_debounce u_deb_left_1 (.clock_50, .rst_n, .button_n(left_1_n), .press(left_1));
	button_debounce u_deb_right_1 (.clock_50, .rst_n, .button_n(right_1_n), .press(right_1));
	button_debounce u_deb_left_2 (.clock_50, .rst_n, .button_n(left_2_n), .press(left_2));
	button_debounce u_deb_right_2 (.clock_50, .rst_n, .button_n(right_2_n), .press(right_2));

	// Players
	player_position #(.START_POS(dodge_pkg::PLAYER1_START)) u_player_1 (
		.clock_50, .rst_n, .play_start, .left(left_1), .right(right_1), .pos(pos_1)
	);
	player_position #(.START_POS(dodge_pkg::PLAYER2_START)) u_player_2 (
		.clock_50, .rst_n, .play_start, .left(left_2), .right(right_2), .pos(pos_2)
	);

	obstacle_field u_field (.clock_50, .rst_n, .play_start, .step, .frame);

	game_control u_control (
		.clock_50, .rst_n, .start_press, .bottom_row(frame[0]),
		.pos_1, .pos_2, .play_start, .step, .screen
	);

	// Display path
	frame_compose u_compose (.screen, .frame, .pos_1, .pos_2, .digit_sel, .digit_data);

	max7219_driver u_driver (
		.clock_50, .rst_n, .digit_data, .digit_sel,
		.max7219_din, .max7219_ncs, .max7219_clk
	);

endmodule

//--- hdl/frame_compose.sv
// Screen select, player overlay and column transpose for one display digit
module frame_compose (
	input  logic [1:0] screen,
	input  dodge_pkg::frame_t frame,
	input  dodge_pkg::row_t pos_1,
	input  dodge_pkg::row_t pos_2,
	input  dodge_pkg::digit_t digit_sel,
	output dodge_pkg::row_t digit_data
);

	dodge_pkg::frame_t shown;
	logic [2:0] col;

	// Digit k shows column 8-k
	assign col = 3'(dodge_pkg::MATRIX_SIZE - 1) - digit_sel;

	always_comb begin
		case (screen)
			dodge_pkg::SCREEN_IDLE: shown = dodge_pkg::START_SCREEN;
			dodge_pkg::SCREEN_OVER: shown = dodge_pkg::OVER_SCREEN;
			default: begin
				shown = frame;
				shown[0] = frame[0] | pos_1 | pos_2;
			end
		endcase
	end

	// Row 0 goes to the MSB
	always_comb begin
		for (int r = 0; r < dodge_pkg::MATRIX_SIZE; r++) begin
			digit_data[dodge_pkg::MATRIX_SIZE-1-r] = shown[r][col];
		end
	end

endmodule

//--- hdl/game_control.sv
// Game FSM with idle/play/over states, step timer and collision test
module game_control (
	input  logic clock_50,
	input  logic rst_n,
	input  logic start_press,
	input  dodge_pkg::row_t bottom_row,
	input  dodge_pkg::row_t pos_1,
	input  dodge_pkg::row_t pos_2,
	output logic play_start,
	output logic step,
	output logic [1:0] screen
);

	logic [1:0] state;
	logic [dodge_pkg::STEP_W-1:0] tick_cnt;
	// High while bottom_row holds the post-step field
	logic check;
	logic hit;

	assign screen = state;
	assign hit = |(bottom_row & (pos_1 | pos_2));

	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			state <= dodge_pkg::SCREEN_IDLE;
			play_start <= 1'b0;
			step <= 1'b0;
			check <= 1'b0;
			tick_cnt <= '0;
		end else begin
			play_start <= start_press && (state != dodge_pkg::SCREEN_PLAY);
			step <= 1'b0;
			check <= step;
			case (state)
				dodge_pkg::SCREEN_PLAY: begin
					if (tick_cnt == dodge_pkg::STEP_W'(dodge_pkg::STEP_TICKS - 1)) begin
						tick_cnt <= '0;
						step <= 1'b1;
					end else begin
						tick_cnt <= tick_cnt + 1'b1;
					end
					// Only place where a round ends
					if (check && hit) begin
						state <= dodge_pkg::SCREEN_OVER;
					end
				end
				default: begin
					// Enter play together with the field clear
					if (play_start) begin
						state <= dodge_pkg::SCREEN_PLAY;
						tick_cnt <= '0;
					end
				end
			endcase
		end
	end

endmodule

//--- hdl/max7219_driver.sv
// MAX7219 serial driver, init frames once then continuous digit refresh
module max7219_driver (
	input  logic clock_50,
	input  logic rst_n,
	input  dodge_pkg::row_t digit_data,
	output dodge_pkg::digit_t digit_sel,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);

	typedef enum logic [1:0] {
		ST_LOAD,
		ST_SHIFT,
		ST_GAP
	} drv_state_t;

	drv_state_t state;
	logic [dodge_pkg::SPI_DIV_W-1:0] div_cnt;
	logic tick;
	// Remaining bits after the one on din
	logic [14:0] shreg;
	logic [3:0] bit_cnt;
	logic init_done;
	logic [15:0] next_word;

	// Half-period tick of the serial clock
	assign tick = (div_cnt == dodge_pkg::SPI_DIV_W'(dodge_pkg::SPI_DIV - 1));

	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else if (tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Address byte then data byte
	always_comb begin
		if (init_done) begin
			next_word = {{5'b0, digit_sel} + 8'd1, digit_data};
		end else begin
			case (digit_sel)
				3'd0: next_word = {dodge_pkg::REG_SHUTDOWN, 8'h01};
				3'd1: next_word = {dodge_pkg::REG_DECODE, 8'h00};
				3'd2: next_word = {dodge_pkg::REG_SCAN_LIMIT, 8'h07};
				3'd3: next_word = {dodge_pkg::REG_INTENSITY, dodge_pkg::INTENSITY};
				default: next_word = {dodge_pkg::REG_DISPLAY_TEST, 8'h00};
			endcase
		end
	end

	// ============================================================
	// Frame sequencer and shifter
	// ============================================================
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_LOAD;
			shreg <= '0;
			bit_cnt <= '0;
			init_done <= 1'b0;
			digit_sel <= '0;
			max7219_din <= 1'b0;
			max7219_ncs <= 1'b1;
			max7219_clk <= 1'b0;
		end else if (tick) begin
			case (state)
				ST_LOAD: begin
					// digit_data is captured here for the whole frame
					{max7219_din, shreg} <= next_word;
					max7219_ncs <= 1'b0;
					bit_cnt <= 4'd15;
					state <= ST_SHIFT;
				end
				ST_SHIFT: begin
					if (!max7219_clk) begin
						max7219_clk <= 1'b1;
					end else begin
						max7219_clk <= 1'b0;
						if (bit_cnt == 4'd0) begin
							max7219_ncs <= 1'b1;
							max7219_din <= 1'b0;
							bit_cnt <= 4'd1;
							state <= ST_GAP;
							if (!init_done && digit_sel == 3'd4) begin
								init_done <= 1'b1;
								digit_sel <= '0;
							end else begin
								digit_sel <= digit_sel + 1'b1;
							end
						end else begin
							// New bit on the falling edge
							{max7219_din, shreg} <= {shreg, 1'b0};
							bit_cnt <= bit_cnt - 1'b1;
						end
					end
				end
				ST_GAP: begin
					if (bit_cnt == 4'd0) begin
						state <= ST_LOAD;
					end else begin
						bit_cnt <= bit_cnt - 1'b1;
					end
				end
				default: state <= ST_LOAD;
			endcase
		end
	end

	// Serial clock idles low outside a frame
	assert property (@(posedge clock_50) disable iff (!rst_n) max7219_ncs |-> !max7219_clk)
		else $error("serial clock high while ncs is high");

endmodule

//--- hdl/obstacle_field.sv
// Falling obstacle rows with an LFSR-driven new top row
module obstacle_field (
	input  logic clock_50,
	input  logic rst_n,
	input  logic play_start,
	input  logic step,
	output dodge_pkg::frame_t frame
);

	logic [7:0] lfsr;
	logic lfsr_fb;
	// High when the coming step is odd-numbered
	logic odd_step;
	dodge_pkg::row_t new_row;

	// Taps 8, 6, 5, 4
	assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

	always_comb begin
		new_row = '0;
		if (odd_step) begin
			new_row[lfsr[2:0]] = 1'b1;
		end
	end

	// ============================================================
	// Row shift and LFSR
	// ============================================================
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			frame <= '0;
			lfsr <= dodge_pkg::LFSR_SEED;
			odd_step <= 1'b1;
		end else if (play_start) begin
			frame <= '0;
			lfsr <= dodge_pkg::LFSR_SEED;
			odd_step <= 1'b1;
		end else if (step) begin
			// Row i takes row i+1, new row enters at the top
			frame <= {new_row, frame[dodge_pkg::MATRIX_SIZE-1:1]};
			lfsr <= {lfsr[6:0], lfsr_fb};
			odd_step <= ~odd_step;
		end
	end

	// Seeded nonzero, so the all-zero lockup state is unreachable
	assert property (@(posedge clock_50) disable iff (!rst_n) lfsr != 8'h00)
		else $error("LFSR reached zero");

endmodule

//--- hdl/player_position.sv
// One player's marker on the bottom row, moved left or right with edge clamping
module player_position #(
	parameter dodge_pkg::row_t START_POS = dodge_pkg::PLAYER1_START
) (
	input  logic clock_50,
	input  logic rst_n,
	input  logic play_start,
	input  logic left,
	input  logic right,
	output dodge_pkg::row_t pos
);

	logic at_left_edge;
	logic at_right_edge;

	assign at_left_edge = pos[dodge_pkg::MATRIX_SIZE-1];
	assign at_right_edge = pos[0];

	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			pos <= START_POS;
		end else if (play_start) begin
			pos <= START_POS;
		end else if (left && !right && !at_left_edge) begin
			// Left is toward bit 7
			pos <= pos << 1;
		end else if (right && !left && !at_right_edge) begin
			pos <= pos >> 1;
		end
	end

	// Marker never vanishes or splits
	assert property (@(posedge clock_50) disable iff (!rst_n) $onehot(pos))
		else $error("player position is not one-hot");

endmodule

//--- list.f
hdl/dodge_pkg.sv
hdl/button_debounce.sv
hdl/player_position.sv
hdl/obstacle_field.sv
hdl/game_control.sv
hdl/frame_compose.sv
hdl/max7219_driver.sv
hdl/dodge_top.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_dodge.sv

//--- testbench/tb_checker.sv
// Serial frame decoder and display comparator for the dodge game testbench
module tb_checker (
	input  logic clock_50,
	input  logic rst_n,
	input  logic max7219_din,
	input  logic max7219_ncs,
	input  logic max7219_clk,
	input  logic exp_valid,
	input  logic [7:0][7:0] exp_digits,
	output int value_errors,
	output int other_errors,
	output int compare_cnt
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [15:0] word;
	int bit_cnt;
	int frame_cnt;
	int cycle;
	// Cycle of the latest change in the expected display
	int last_disturb;
	int rise_cycle;
	int win_start;
	int exp_addr;
	bit refresh_ok;
	// Previous clock edge was inside reset
	bit after_reset;
	logic valid_s;
	logic [7:0][7:0] exp_s;
	// Index d holds digit d+1
	logic [7:0][7:0] shadow;

	function automatic logic [15:0] init_word(input int idx);
		case (idx)
			0: return {dodge_pkg::REG_SHUTDOWN, 8'h01};
			1: return {dodge_pkg::REG_DECODE, 8'h00};
			2: return {dodge_pkg::REG_SCAN_LIMIT, 8'h07};
			3: return {dodge_pkg::REG_INTENSITY, 8'h0A};
			default: return {dodge_pkg::REG_DISPLAY_TEST, 8'h00};
		endcase
	endfunction

	initial begin
		value_errors = 0;
		other_errors = 0;
		compare_cnt = 0;
		word = '0;
		bit_cnt = 0;
		frame_cnt = 0;
		cycle = 0;
		last_disturb = 0;
		rise_cycle = 0;
		win_start = 0;
		exp_addr = 1;
		refresh_ok = 1'b0;
		after_reset = 1'b0;
	end

	// ============================================================
	// Line levels around reset, expected display sampling
	// ============================================================
	always @(posedge clock_50) begin
		cycle = cycle + 1;
		if (after_reset) begin
			if (max7219_ncs !== 1'b1 || max7219_clk !== 1'b0 || max7219_din !== 1'b0) begin
				$display("CHECK FAILED at %0t: serial lines not idle near reset (ncs %b clk %b din %b)",
					$time, max7219_ncs, max7219_clk, max7219_din);
				value_errors++;
			end
		end
		after_reset = !rst_n;
		if (!exp_valid || exp_digits !== exp_s) begin
			last_disturb = cycle;
		end
		valid_s = exp_valid;
		exp_s = exp_digits;
	end

	// ============================================================
	// Frame capture
	// ============================================================
	always @(negedge max7219_ncs) begin
		bit_cnt = 0;
	end

	// din only moves while clk is low
	always @(posedge max7219_clk) begin
		if (!max7219_ncs) begin
			word = {word[14:0], max7219_din};
			bit_cnt = bit_cnt + 1;
		end
	end

	always @(posedge max7219_ncs) begin
		if (rst_n === 1'b1) begin
			decode_frame();
		end
	end

	task automatic decode_frame();
		if (bit_cnt != 16) begin
			$display("Error at %0t: serial frame ended after %0d bits instead of 16",
				$time, bit_cnt);
			other_errors++;
			refresh_ok = 1'b0;
		end else if (frame_cnt < 5) begin
			if (word !== init_word(frame_cnt)) begin
				$display("CHECK FAILED at %0t: init frame %0d is %04h, expected %04h",
					$time, frame_cnt, word, init_word(frame_cnt));
				value_errors++;
			end
		end else begin
			store_digit(word[15:8], word[7:0]);
		end
		frame_cnt++;
		rise_cycle = cycle;
	endtask

	task automatic store_digit(input logic [7:0] addr, input logic [7:0] data);
		if (addr != 8'(exp_addr)) begin
			$display("CHECK FAILED at %0t: digit address %0d, expected %0d", $time, addr, exp_addr);
			value_errors++;
			refresh_ok = 1'b0;
		end else begin
			// Refresh window opens at the end of the frame before digit 1
			if (addr == 8'd1) begin
				win_start = rise_cycle;
				refresh_ok = 1'b1;
			end
			shadow[addr-1] = data;
			if (addr == 8'd8 && refresh_ok) begin
				compare_refresh();
			end
		end
		exp_addr = (exp_addr % 8) + 1;
	endtask

	// Only refreshes with a steady expected display are compared
	task automatic compare_refresh();
		if (valid_s && last_disturb < win_start) begin
			compare_cnt++;
			for (int d = 0; d < 8; d++) begin
				if (shadow[d] !== exp_s[d]) begin
					$display("CHECK FAILED at %0t: digit %0d shows %08b, expected %08b",
						$time, d + 1, shadow[d], exp_s[d]);
					value_errors++;
				end
			end
		end
	endtask

endmodule

//--- testbench/tb_clock_gen.sv
// Testbench clock and reset source, 10 ns clock with reset held for two cycles
module tb_clock_gen (
	output logic clock_50,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clock_50 = 1'b0;
		forever #5 clock_50 = ~clock_50;
	end

	// Released on the second rising edge
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clock_50);
		rst_n <= 1'b1;
	end

endmodule

//--- testbench/tb_dodge.sv
// Dodge game testbench top with button stimulus and a reference game model
module tb_dodge;
	timeunit 1ns;
	timeprecision 1ps;

	// Slowest round ends within about 60 steps of 1200 cycles, plus margin
	localparam int TIMEOUT_CYCLES = 200_000;
	localparam int PRESS_CYCLES = 20;

	logic clock_50;
	logic rst_n;
	logic start_button_n;
	logic left_1_n;
	logic right_1_n;
	logic left_2_n;
	logic right_2_n;
	logic max7219_din;
	logic max7219_ncs;
	logic max7219_clk;

	// Reference model
	logic [1:0] screen_m;
	dodge_pkg::frame_t field_m;
	dodge_pkg::row_t pos_1_m;
	dodge_pkg::row_t pos_2_m;
	logic [7:0] lfsr_m;
	int step_idx;
	logic exp_valid;
	logic [7:0][7:0] exp_digits;

	int value_errors;
	int other_errors;
	int compare_cnt;
	int cycle_cnt;
	int seed;
	int moves;
	int unsigned pick;

	tb_clock_gen u_clock (.clock_50, .rst_n);

	dodge_top dut (
		.clock_50, .rst_n, .start_button_n, .left_1_n, .right_1_n, .left_2_n, .right_2_n,
		.max7219_din, .max7219_ncs, .max7219_clk
	);

	tb_checker u_checker (
		.clock_50, .rst_n, .max7219_din, .max7219_ncs, .max7219_clk,
		.exp_valid, .exp_digits, .value_errors, .other_errors, .compare_cnt
	);

	// ============================================================
	// Reference functions
	// ============================================================
	// Digit k holds column 8-k, row 0 in the MSB
	function automatic logic [7:0][7:0] transpose_digits(input dodge_pkg::frame_t f);
		logic [7:0][7:0] d;
		for (int k = 1; k <= 8; k++) begin
			for (int r = 0; r < 8; r++) begin
				d[k-1][7-r] = f[r][8-k];
			end
		end
		return d;
	endfunction

	function automatic dodge_pkg::frame_t shown_frame(input logic [1:0] screen,
		input dodge_pkg::frame_t field, input dodge_pkg::row_t p1, input dodge_pkg::row_t p2);
		dodge_pkg::frame_t f;
		f = field;
		f[0] = field[0] | p1 | p2;
		if (screen == dodge_pkg::SCREEN_IDLE) begin
			f = dodge_pkg::START_SCREEN;
		end else if (screen == dodge_pkg::SCREEN_OVER) begin
			f = dodge_pkg::OVER_SCREEN;
		end
		return f;
	endfunction

	// Left goes toward bit 7, the marker stops at the edge
	function automatic dodge_pkg::row_t move_marker(input dodge_pkg::row_t pos, input bit to_left);
		if (to_left) begin
			return pos[7] ? pos : pos << 1;
		end
		return pos[0] ? pos : pos >> 1;
	endfunction

	// Odd steps bring one dot at the low 3 LFSR bits, even steps an empty row
	function automatic dodge_pkg::row_t lfsr_row(input logic [7:0] lfsr, input int idx);
		dodge_pkg::row_t r;
		r = '0;
		if (idx % 2 == 1) begin
			r[lfsr[2:0]] = 1'b1;
		end
		return r;
	endfunction

	assign exp_digits = transpose_digits(shown_frame(screen_m, field_m, pos_1_m, pos_2_m));

	// Model step, timed by the DUT step pulse
	always @(posedge clock_50) begin
		dodge_pkg::frame_t next_field;
		if (dut.step && screen_m == dodge_pkg::SCREEN_PLAY) begin
			for (int i = 0; i < 7; i++) begin
				next_field[i] = field_m[i+1];
			end
			next_field[7] = lfsr_row(lfsr_m, step_idx + 1);
			field_m <= next_field;
			// Taps at 8, 6, 5 and 4
			lfsr_m <= {lfsr_m[6:0], lfsr_m[7] ^ lfsr_m[5] ^ lfsr_m[4] ^ lfsr_m[3]};
			step_idx <= step_idx + 1;
			if ((next_field[0] & (pos_1_m | pos_2_m)) != '0) begin
				screen_m <= dodge_pkg::SCREEN_OVER;
			end
		end
	end

	// ============================================================
	// Stimulus
	// ============================================================
	task automatic set_button(input int which, input logic level);
		case (which)
			0: start_button_n <= level;
			1: left_1_n <= level;
			2: right_1_n <= level;
			3: left_2_n <= level;
			default: right_2_n <= level;
		endcase
	endtask

	task automatic update_model(input int which);
		case (which)
			0: begin
				screen_m <= dodge_pkg::SCREEN_PLAY;
				field_m <= '0;
				lfsr_m <= dodge_pkg::LFSR_SEED;
				step_idx <= 0;
				pos_1_m <= dodge_pkg::PLAYER1_START;
				pos_2_m <= dodge_pkg::PLAYER2_START;
			end
			1: pos_1_m <= move_marker(pos_1_m, 1'b1);
			2: pos_1_m <= move_marker(pos_1_m, 1'b0);
			3: pos_2_m <= move_marker(pos_2_m, 1'b1);
			default: pos_2_m <= move_marker(pos_2_m, 1'b0);
		endcase
	endtask

	// Expected display is not valid while the DUT takes the press
	task automatic press_button(input int which);
		exp_valid <= 1'b0;
		set_button(which, 1'b0);
		repeat (PRESS_CYCLES) @(posedge clock_50);
		set_button(which, 1'b1);
		update_model(which);
		repeat (PRESS_CYCLES) @(posedge clock_50);
		exp_valid <= 1'b1;
	endtask

	task automatic wait_compares(input int n);
		int target;
		target = compare_cnt + n;
		while (compare_cnt < target) begin
			@(posedge clock_50);
		end
	endtask

	task automatic end_run(input bit timed_out);
		$display("Errors: %0d value, %0d other, %0d timeout; %0d refreshes compared",
			value_errors, other_errors, timed_out, compare_cnt);
		if (timed_out || value_errors != 0 || other_errors != 0) begin
			$display("Simulation finished: FAIL");
		end else begin
			$display("Simulation finished: PASS");
		end
		$finish;
	endtask

	always @(posedge clock_50) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			end_run(1'b1);
		end
	end

	initial begin
		start_button_n = 1'b1;
		left_1_n = 1'b1;
		right_1_n = 1'b1;
		left_2_n = 1'b1;
		right_2_n = 1'b1;
		screen_m = dodge_pkg::SCREEN_IDLE;
		field_m = '0;
		pos_1_m = dodge_pkg::PLAYER1_START;
		pos_2_m = dodge_pkg::PLAYER2_START;
		lfsr_m = dodge_pkg::LFSR_SEED;
		step_idx = 0;
		exp_valid = 1'b1;
		cycle_cnt = 0;
		seed = 96234;
		pick = $urandom(seed);
		wait (rst_n === 1'b1);
		@(posedge clock_50);
		// Start screen in idle
		wait_compares(2);
		press_button(0);
		// Moves end long before the first dot reaches row 0
		moves = 4 + $urandom % 9;
		repeat (moves) begin
			pick = $urandom % 4;
			press_button(1 + pick);
		end
		wait_compares(1);
		wait (screen_m == dodge_pkg::SCREEN_OVER);
		wait_compares(2);
		// Second round with players back at their start columns
		press_button(0);
		wait_compares(1);
		wait (screen_m == dodge_pkg::SCREEN_OVER);
		wait_compares(1);
		end_run(1'b0);
	end

endmodule
